// File: gpio_cfg_pkg.sv
// assumes GDW <= DAT and DAT == 2*GDW for the set/clear word; pins arrive asynchronous to clk
package gpio_cfg_pkg;

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////

    localparam int unsigned GDW = 16;  // gpio pin count
    localparam int unsigned DAT = 32;  // bus data width
    localparam int unsigned ADR = 3;   // bus address width

    // flops on gpio_i before anything looks at it
    // at least 2, the shift in gpio_in_capture assumes it
    localparam int unsigned SYNC_STAGES = 2;

////////////////////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////////////////////

    // read/write control registers
    localparam logic [ADR-1:0] ADDR_OE    = ADR'(0);  // output enable
    localparam logic [ADR-1:0] ADDR_OD    = ADR'(1);  // output data
    localparam logic [ADR-1:0] ADDR_IE    = ADR'(2);  // input enable

    // input side
    localparam logic [ADR-1:0] ADDR_ID    = ADR'(3);  // masked pins (read only)
    localparam logic [ADR-1:0] ADDR_EVT   = ADR'(4);  // rising edge flags (w1c)

    // write only, reads back zero
    localparam logic [ADR-1:0] ADDR_OD_SC = ADR'(5);  // od set/clear masks

    // 6 and 7 unused
    // writes dropped, reads zero

endpackage

// File: gpio_bus_pkg.sv
// one bus write word with two views; the struct only lines up while DAT is twice GDW
package gpio_bus_pkg;

////////////////////////////////////////////////////////////////////////////
// set/clear view
////////////////////////////////////////////////////////////////////////////

    // od bits to force, both halves in one write
    typedef struct packed {
        logic [gpio_cfg_pkg::GDW-1:0] set;  // upper half (bits forced high)
        logic [gpio_cfg_pkg::GDW-1:0] clr;  // lower half (bits forced low)
    } gpio_sc_t;

////////////////////////////////////////////////////////////////////////////
// write data
////////////////////////////////////////////////////////////////////////////

    // plain word for oe/od/ie and the evt clear mask
    // sc view only meaningful at ADDR_OD_SC
    typedef union packed {
        logic [gpio_cfg_pkg::DAT-1:0] word;  // whole bus word
        gpio_sc_t                     sc;    // set in [31:16], clr in [15:0]
    } gpio_wdata_u;

endpackage

// File: gpio_csr_if.sv
// register contents only, no clock in here; every field is GDW wide and driven by one side
interface gpio_csr_if ();

    // control registers, owned by gpio_out_regs
    logic [gpio_cfg_pkg::GDW-1:0] oe;   // output enable
    logic [gpio_cfg_pkg::GDW-1:0] od;   // output data
    logic [gpio_cfg_pkg::GDW-1:0] ie;   // input enable

    // input state, owned by gpio_in_capture
    logic [gpio_cfg_pkg::GDW-1:0] id;   // synced pins masked by ie
    logic [gpio_cfg_pkg::GDW-1:0] evt;  // sticky rising edge flags

    // output side drives the control regs
    modport out_side (
        output oe, od, ie
    );

    // input side needs ie for masking
    modport in_side (
        input  ie,
        output id, evt
    );

    // read combiner sees everything
    modport rd_side (
        input oe, od, ie, id, evt
    );

endinterface

// File: gpio_out_regs.sv
// writes land on the wen edge with no handshake; only oe, od, ie and od set/clear decoded here
module gpio_out_regs (
    input  logic                         clk,
    input  logic                         rst,
    // bus write strobes
    input  logic                         wen,  // write enable
    input  logic [gpio_cfg_pkg::ADR-1:0] wad,  // write address
    input  gpio_bus_pkg::gpio_wdata_u    wdt,  // write data
    // register contents out
    gpio_csr_if.out_side                 csr
);

////////////////////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////////////////////

    logic [gpio_cfg_pkg::GDW-1:0] oe_q;    // output enable
    logic [gpio_cfg_pkg::GDW-1:0] od_q;    // output data
    logic [gpio_cfg_pkg::GDW-1:0] ie_q;    // input enable

    logic [gpio_cfg_pkg::GDW-1:0] wdt_lo;  // plain word cut to pin width
    logic [gpio_cfg_pkg::GDW-1:0] od_sc;   // od after a set/clear write

    // upper bus bits dropped for plain registers
    assign wdt_lo = wdt.word[gpio_cfg_pkg::GDW-1:0];

    // clear first, then set
    // so a bit in both masks ends high
    assign od_sc = (od_q & ~wdt.sc.clr) | wdt.sc.set;

////////////////////////////////////////////////////////////////////////////
// write decode
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            oe_q <= '0;  // no pin driven out of reset
            od_q <= '0;
            ie_q <= '0;  // inputs masked
        end else if (wen) begin
            case (wad)
                gpio_cfg_pkg::ADDR_OE:    oe_q <= wdt_lo;
                gpio_cfg_pkg::ADDR_OD:    od_q <= wdt_lo;
                gpio_cfg_pkg::ADDR_IE:    ie_q <= wdt_lo;
                gpio_cfg_pkg::ADDR_OD_SC: od_q <= od_sc;  // same word, sc view
                default: ;  // id, evt and unused belong elsewhere or nowhere
            endcase
        end
    end

////////////////////////////////////////////////////////////////////////////
// register contents to the interface
////////////////////////////////////////////////////////////////////////////

    // straight from the flops
    // top level pins follow on the same cycle as the write edge
    assign csr.oe = oe_q;
    assign csr.od = od_q;
    assign csr.ie = ie_q;  // also feeds input masking

endmodule

// File: gpio_in_capture.sv
// gpio_i may be asynchronous; SYNC_STAGES must be at least 2; only rising edges are flagged
module gpio_in_capture (
    input  logic                         clk,
    input  logic                         rst,
    // bus write strobes, only ADDR_EVT decoded
    input  logic                         wen,  // write enable
    input  logic [gpio_cfg_pkg::ADR-1:0] wad,  // write address
    input  gpio_bus_pkg::gpio_wdata_u    wdt,  // write data, ones clear flags
    // raw pins
    input  logic [gpio_cfg_pkg::GDW-1:0] gpio_i,
    // register contents
    gpio_csr_if.in_side                  csr
);

////////////////////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////////////////////

    // stage 0 samples the pins, last stage is safe to use
    logic [gpio_cfg_pkg::SYNC_STAGES-1:0][gpio_cfg_pkg::GDW-1:0] sync_q;

    logic [gpio_cfg_pkg::GDW-1:0] id_c;     // masked synced pins
    logic [gpio_cfg_pkg::GDW-1:0] id_q;     // id one cycle back
    logic [gpio_cfg_pkg::GDW-1:0] rise;     // 0 -> 1 this cycle
    logic [gpio_cfg_pkg::GDW-1:0] evt_clr;  // w1c mask from the bus
    logic [gpio_cfg_pkg::GDW-1:0] evt_q;    // sticky flags

////////////////////////////////////////////////////////////////////////////
// synchronizer and masking
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[gpio_cfg_pkg::SYNC_STAGES-2:0], gpio_i};  // shift up
        end
    end

    // valid after the second sampling edge
    assign id_c = sync_q[gpio_cfg_pkg::SYNC_STAGES-1] & csr.ie;

////////////////////////////////////////////////////////////////////////////
// rising edge events
////////////////////////////////////////////////////////////////////////////

    // disabled pins are forced low in id_c so they never rise
    assign rise = id_c & ~id_q;

    // clear mask only on a write to the event register
    assign evt_clr = (wen && (wad == gpio_cfg_pkg::ADDR_EVT))
                   ? wdt.word[gpio_cfg_pkg::GDW-1:0]
                   : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_q  <= '0;
            evt_q <= '0;
        end else begin
            id_q  <= id_c;                      // edge history
            evt_q <= (evt_q & ~evt_clr) | rise; // new edge beats a clear
        end
    end

    assign csr.id  = id_c;
    assign csr.evt = evt_q;

endmodule

// File: gpio_read_mux.sv
// one cycle read latency; rdt holds between reads; od set/clear and unused addresses read zero
module gpio_read_mux (
    input  logic                         clk,
    input  logic                         rst,
    // bus read strobes
    input  logic                         ren,  // read enable
    input  logic [gpio_cfg_pkg::ADR-1:0] rad,  // read address
    // register contents
    gpio_csr_if.rd_side                  csr,
    // registered read data
    output logic [gpio_cfg_pkg::DAT-1:0] rdt
);

    logic [gpio_cfg_pkg::DAT-1:0] rd_next;  // decoded, zero extended

    // upper DAT-GDW bits stay zero
    always_comb begin
        rd_next = '0;
        case (rad)
            gpio_cfg_pkg::ADDR_OE:  rd_next[gpio_cfg_pkg::GDW-1:0] = csr.oe;
            gpio_cfg_pkg::ADDR_OD:  rd_next[gpio_cfg_pkg::GDW-1:0] = csr.od;
            gpio_cfg_pkg::ADDR_IE:  rd_next[gpio_cfg_pkg::GDW-1:0] = csr.ie;
            gpio_cfg_pkg::ADDR_ID:  rd_next[gpio_cfg_pkg::GDW-1:0] = csr.id;
            gpio_cfg_pkg::ADDR_EVT: rd_next[gpio_cfg_pkg::GDW-1:0] = csr.evt;
            default: ;  // write only or unused
        endcase
    end

    // pre-edge contents, so a same-cycle write is not seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdt <= '0;
        end else if (ren) begin
            rdt <= rd_next;
        end
    end

endmodule

// File: gpio_ctrl.sv
// no handshake, every strobe taken in its cycle; gpio_i gets synchronized inside
module gpio_ctrl (
    // system
    input  logic                         clk,
    input  logic                         rst,
    // write strobes
    input  logic                         wen,     // write enable
    input  logic [gpio_cfg_pkg::ADR-1:0] wad,     // write address
    input  logic [gpio_cfg_pkg::DAT-1:0] wdt,     // write data
    // read strobes
    input  logic                         ren,     // read enable
    input  logic [gpio_cfg_pkg::ADR-1:0] rad,     // read address
    output logic [gpio_cfg_pkg::DAT-1:0] rdt,     // read data, one cycle later
    // pins
    output logic [gpio_cfg_pkg::GDW-1:0] gpio_o,  // output data
    output logic [gpio_cfg_pkg::GDW-1:0] gpio_e,  // output enable, active high
    input  logic [gpio_cfg_pkg::GDW-1:0] gpio_i   // raw input
);

////////////////////////////////////////////////////////////////////////////
// shared wiring
////////////////////////////////////////////////////////////////////////////

    gpio_csr_if csr ();  // register contents between the blocks

    gpio_bus_pkg::gpio_wdata_u wdt_u;  // bus word with both views

    assign wdt_u = gpio_bus_pkg::gpio_wdata_u'(wdt);

////////////////////////////////////////////////////////////////////////////
// output side, input side, read combiner
////////////////////////////////////////////////////////////////////////////

    gpio_out_regs u_out (
        .clk (clk),
        .rst (rst),
        .wen (wen),
        .wad (wad),
        .wdt (wdt_u),
        .csr (csr.out_side)
    );

    gpio_in_capture u_in (
        .clk    (clk),
        .rst    (rst),
        .wen    (wen),
        .wad    (wad),
        .wdt    (wdt_u),  // only the plain word is used here
        .gpio_i (gpio_i),
        .csr    (csr.in_side)
    );

    gpio_read_mux u_rd (
        .clk (clk),
        .rst (rst),
        .ren (ren),
        .rad (rad),
        .csr (csr.rd_side),
        .rdt (rdt)
    );

    // pins straight off the registers
    assign gpio_o = csr.od;
    assign gpio_e = csr.oe;

endmodule

// File: gpio_ctrl_tb.sv
// directed tests only; inputs change 2 ns after each rising edge; assumes GDW is 16 and DAT is 32
module gpio_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

////////////////////////////////////////////////////////////////////////////
// dut signals and bookkeeping
////////////////////////////////////////////////////////////////////////////

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         wen;
    logic [gpio_cfg_pkg::ADR-1:0] wad;
    logic [gpio_cfg_pkg::DAT-1:0] wdt;
    logic                         ren;
    logic [gpio_cfg_pkg::ADR-1:0] rad;
    logic [gpio_cfg_pkg::DAT-1:0] rdt;
    logic [gpio_cfg_pkg::GDW-1:0] gpio_o;
    logic [gpio_cfg_pkg::GDW-1:0] gpio_e;
    logic [gpio_cfg_pkg::GDW-1:0] gpio_i;  // pin model, driven by the tests

    integer seed = 16;  // $random state
    int errors = 0;     // failed checks over the whole run
    int tests_ok = 0;
    int tests_bad = 0;

    // expected control registers
    logic [gpio_cfg_pkg::GDW-1:0] oe_m;
    logic [gpio_cfg_pkg::GDW-1:0] od_m;
    logic [gpio_cfg_pkg::GDW-1:0] ie_m;

    gpio_ctrl UUT (
        .clk    (clk),
        .rst    (rst),
        .wen    (wen),
        .wad    (wad),
        .wdt    (wdt),
        .ren    (ren),
        .rad    (rad),
        .rdt    (rdt),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

    always #10 clk = ~clk;  // 20 ns period

////////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////////

    function automatic logic [gpio_cfg_pkg::DAT-1:0] widen(input logic [gpio_cfg_pkg::GDW-1:0] v);
        return {{(gpio_cfg_pkg::DAT - gpio_cfg_pkg::GDW){1'b0}}, v};  // zero extend
    endfunction

    function automatic logic [gpio_cfg_pkg::GDW-1:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        return r[gpio_cfg_pkg::GDW-1:0];
    endfunction

    // bit by bit, set has priority over clr
    function automatic logic [gpio_cfg_pkg::GDW-1:0] apply_set_clear(
        input logic [gpio_cfg_pkg::GDW-1:0] old,
        input logic [gpio_cfg_pkg::GDW-1:0] set,
        input logic [gpio_cfg_pkg::GDW-1:0] clr
    );
        logic [gpio_cfg_pkg::GDW-1:0] res;
        int i;
        res = old;
        for (i = 0; i < gpio_cfg_pkg::GDW; i++) begin
            if (set[i]) begin
                res[i] = 1'b1;
            end else if (clr[i]) begin
                res[i] = 1'b0;
            end
        end
        return res;
    endfunction

    task automatic run_cycles(input int n);
        int k;
        k = 0;
        while (k < n) begin
            @(posedge clk);
            #2;  // back to the drive point
            k++;
        end
    endtask

    // one cycle, lands on the next edge
    task automatic bus_write(input logic [gpio_cfg_pkg::ADR-1:0] addr,
                             input logic [gpio_cfg_pkg::DAT-1:0] data);
        wen = 1'b1;
        wad = addr;
        wdt = data;
        @(posedge clk);
        #2;
        wen = 1'b0;
    endtask

    // rdt sampled after the edge that takes the read
    task automatic bus_read(input logic [gpio_cfg_pkg::ADR-1:0] addr,
                            output logic [gpio_cfg_pkg::DAT-1:0] data);
        ren = 1'b1;
        rad = addr;
        @(posedge clk);
        #2;
        ren = 1'b0;
        data = rdt;
    endtask

    task automatic check_val(input string name, input logic [gpio_cfg_pkg::DAT-1:0] exp,
                             input logic [gpio_cfg_pkg::DAT-1:0] act);
        assert (act === exp) else begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input logic [gpio_cfg_pkg::ADR-1:0] addr,
                             input logic [gpio_cfg_pkg::GDW-1:0] exp);
        logic [gpio_cfg_pkg::DAT-1:0] d;
        bus_read(addr, d);
        check_val($sformatf("rdt (addr %0d)", addr), widen(exp), d);
    endtask

    // repeated reads until the value shows up or the limit runs out
    task automatic poll_read(input logic [gpio_cfg_pkg::ADR-1:0] addr,
                             input logic [gpio_cfg_pkg::GDW-1:0] exp, input int limit);
        logic [gpio_cfg_pkg::DAT-1:0] d;
        int tries;
        logic hit;
        tries = 0;
        hit = 1'b0;
        while (!hit && tries < limit) begin
            bus_read(addr, d);
            hit = (d === widen(exp));
            tries++;
        end
        assert (hit) else begin
            $display("timeout at %0t: register %0d never read %h within %0d reads",
                     $time, addr, exp, limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            tests_bad++;
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int e0;
        int a;
        e0 = errors;
        check_val("gpio_e", '0, widen(gpio_e));
        check_val("gpio_o", '0, widen(gpio_o));
        for (a = 0; a < 8; a++) begin
            check_reg(a[gpio_cfg_pkg::ADR-1:0], '0);  // every address, used or not
        end
        report_test("reset_state", e0);
    endtask

    task automatic test_plain_writes();
        int e0;
        int n;
        logic [gpio_cfg_pkg::DAT-1:0] v;
        e0 = errors;
        for (n = 0; n < 4; n++) begin
            v = $random(seed);
            bus_write(gpio_cfg_pkg::ADDR_OE, v);
            oe_m = v[gpio_cfg_pkg::GDW-1:0];  // upper bits dropped
            check_val("gpio_e", widen(oe_m), widen(gpio_e));
            v = $random(seed);
            bus_write(gpio_cfg_pkg::ADDR_OD, v);
            od_m = v[gpio_cfg_pkg::GDW-1:0];
            check_val("gpio_o", widen(od_m), widen(gpio_o));
            v = $random(seed);
            bus_write(gpio_cfg_pkg::ADDR_IE, v);
            ie_m = v[gpio_cfg_pkg::GDW-1:0];
            check_reg(gpio_cfg_pkg::ADDR_OE, oe_m);
            check_reg(gpio_cfg_pkg::ADDR_OD, od_m);
            check_reg(gpio_cfg_pkg::ADDR_IE, ie_m);
        end
        // read only and unused, nothing may move
        v = $random(seed);
        bus_write(gpio_cfg_pkg::ADDR_ID, v);
        bus_write(3'd6, v);
        bus_write(3'd7, v);
        check_val("gpio_e", widen(oe_m), widen(gpio_e));
        check_val("gpio_o", widen(od_m), widen(gpio_o));
        check_reg(gpio_cfg_pkg::ADDR_OE, oe_m);
        check_reg(gpio_cfg_pkg::ADDR_OD, od_m);
        check_reg(gpio_cfg_pkg::ADDR_IE, ie_m);
        check_reg(gpio_cfg_pkg::ADDR_ID, '0);  // pins still low
        check_reg(gpio_cfg_pkg::ADDR_OD_SC, '0);
        check_reg(3'd6, '0);
        check_reg(3'd7, '0);
        report_test("plain_writes", e0);
    endtask

    task automatic test_set_clear();
        int e0;
        int n;
        gpio_bus_pkg::gpio_wdata_u w;
        logic [gpio_cfg_pkg::GDW-1:0] set_m;
        logic [gpio_cfg_pkg::GDW-1:0] clr_m;
        e0 = errors;
        bus_write(gpio_cfg_pkg::ADDR_OD, 32'h0000_a5c3);  // known start
        od_m = 16'ha5c3;
        check_val("gpio_o", widen(od_m), widen(gpio_o));
        for (n = 0; n < 6; n++) begin
            set_m = rand16();
            clr_m = rand16() | (set_m & rand16());  // some bits in both masks
            if (n == 0) begin
                set_m = 16'h0ff0;
                clr_m = 16'h00ff;  // overlap in 0x00f0
            end
            w.sc.set = set_m;
            w.sc.clr = clr_m;
            bus_write(gpio_cfg_pkg::ADDR_OD_SC, w.word);
            od_m = apply_set_clear(od_m, set_m, clr_m);
            check_val("gpio_o", widen(od_m), widen(gpio_o));
            check_reg(gpio_cfg_pkg::ADDR_OD, od_m);
        end
        report_test("set_clear", e0);
    endtask

    task automatic test_input_mask();
        int e0;
        int n;
        logic [gpio_cfg_pkg::GDW-1:0] pins;
        e0 = errors;
        for (n = 0; n < 5; n++) begin
            pins = rand16();
            ie_m = rand16();
            bus_write(gpio_cfg_pkg::ADDR_IE, widen(ie_m));
            gpio_i = pins;
            run_cycles(gpio_cfg_pkg::SYNC_STAGES + 1);  // through the synchronizer
            check_reg(gpio_cfg_pkg::ADDR_ID, pins & ie_m);
        end
        // all enables off, all pins read low
        ie_m = '0;
        bus_write(gpio_cfg_pkg::ADDR_IE, '0);
        check_reg(gpio_cfg_pkg::ADDR_ID, '0);
        report_test("input_mask", e0);
    endtask

    task automatic test_edge_events();
        int e0;
        logic [gpio_cfg_pkg::GDW-1:0] rise_m;
        logic [gpio_cfg_pkg::GDW-1:0] keep_m;
        logic [gpio_cfg_pkg::GDW-1:0] clr_m;
        logic [gpio_cfg_pkg::GDW-1:0] dis_m;
        e0 = errors;
        gpio_i = '0;
        run_cycles(gpio_cfg_pkg::SYNC_STAGES + 2);  // pins settle low
        ie_m = '1;
        bus_write(gpio_cfg_pkg::ADDR_IE, widen(ie_m));
        run_cycles(2);
        bus_write(gpio_cfg_pkg::ADDR_EVT, widen('1));  // flags left by earlier tests
        check_reg(gpio_cfg_pkg::ADDR_EVT, '0);

        // some pins rise
        rise_m = rand16() | 16'h0001;
        gpio_i = rise_m;
        poll_read(gpio_cfg_pkg::ADDR_EVT, rise_m, 8);
        check_reg(gpio_cfg_pkg::ADDR_EVT, rise_m);

        // write ones to clear
        clr_m = rand16();
        bus_write(gpio_cfg_pkg::ADDR_EVT, widen(clr_m));
        check_reg(gpio_cfg_pkg::ADDR_EVT, rise_m & ~clr_m);

        // falling pins add nothing, flags emptied first so a fall would show
        bus_write(gpio_cfg_pkg::ADDR_EVT, widen('1));
        keep_m = rise_m & rand16() & ~16'h0001;  // pin 0 always falls
        gpio_i = keep_m;
        run_cycles(gpio_cfg_pkg::SYNC_STAGES + 2);
        check_reg(gpio_cfg_pkg::ADDR_EVT, '0);

        // disabled pins never flag
        gpio_i = '0;
        run_cycles(gpio_cfg_pkg::SYNC_STAGES + 2);
        dis_m = rand16() | 16'h8000;
        ie_m = ~dis_m;
        bus_write(gpio_cfg_pkg::ADDR_IE, widen(ie_m));
        bus_write(gpio_cfg_pkg::ADDR_EVT, widen('1));
        gpio_i = '1;  // every pin rises
        poll_read(gpio_cfg_pkg::ADDR_EVT, ie_m, 8);
        run_cycles(gpio_cfg_pkg::SYNC_STAGES + 2);
        check_reg(gpio_cfg_pkg::ADDR_EVT, ie_m);
        report_test("edge_events", e0);
    endtask

////////////////////////////////////////////////////////////////////////////
// sequence
////////////////////////////////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        wen = 1'b0;
        wad = '0;
        wdt = '0;
        ren = 1'b0;
        rad = '0;
        gpio_i = '0;
        oe_m = '0;
        od_m = '0;
        ie_m = '0;
        run_cycles(2);  // reset over two edges
        rst = 1'b0;

        test_reset_state();
        test_plain_writes();
        test_set_clear();
        test_input_mask();
        test_edge_events();

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: gpio_ctrl.f
gpio_cfg_pkg.sv
gpio_bus_pkg.sv
gpio_csr_if.sv
gpio_out_regs.sv
gpio_in_capture.sv
gpio_read_mux.sv
gpio_ctrl.sv
gpio_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the gpio_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

# rtl modules carry no timescale, the testbench declares its own units
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module gpio_ctrl_tb -f gpio_ctrl.f -o gpio_ctrl_sim

./obj_dir/gpio_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
